// ==== verilog/cnn_cfg_pkg.sv ====
// IMG_DIM must be a power of two and at least 2; image and conv RAM are addressed as {row, col}
package cnn_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Image geometry
  ////////////////////////////////////////////////////////////////////////////

  // Square image edge in pixels
  localparam int IMG_DIM  = 8;
  localparam int IMG_BITS = 3;

  // Flat address of a pixel or conv result
  localparam int ADDR_BITS = 2 * IMG_BITS;

  // Pooled map, 2x2 blocks
  localparam int POOL_DIM       = IMG_DIM / 2;
  localparam int POOL_BITS      = IMG_BITS - 1;
  localparam int POOL_ADDR_BITS = 2 * POOL_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////////////////////

  // Pixels unsigned, weights signed
  localparam int PIX_BITS = 8;
  localparam int WGT_BITS = 8;

  // Signed conv result, nine full-scale products fit
  localparam int ACC_BITS = 20;

  // 3x3 kernel; TAP_BITS also sizes the weight ROM address
  localparam int KERNEL_TAPS = 9;
  localparam int TAP_BITS    = 4;

endpackage

// ==== verilog/cnn_ctrl_pkg.sv ====
// Controller encodings only; window rows are one-hot with the top row in bit 2
package cnn_ctrl_pkg;

  // Sequencer states, in run order
  typedef enum logic [2:0] {
    LOAD_W,
    FILL_WIN,
    SHIFT_COL,
    WRITE_CONV,
    READ_POOL,
    WRITE_POOL,
    DONE
  } ctrl_state_e;

  // Window row select, one-hot
  typedef logic [2:0] win_row_t;

  localparam win_row_t ROW_NONE = 3'b000;
  localparam win_row_t ROW_TOP  = 3'b100;
  localparam win_row_t ROW_MID  = 3'b010;
  localparam win_row_t ROW_BOT  = 3'b001;

endpackage

// ==== verilog/conv_controller.sv ====
// Starts on reset release with no stall input; memories must answer in the same cycle
`timescale 1ns/10ps

module conv_controller
  import cnn_cfg_pkg::*;
  import cnn_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  output logic [TAP_BITS-1:0]       rom_w_a,
  output logic                      rom_w_oe,
  output logic                      w_load,
  output logic [ADDR_BITS-1:0]      rom_if_a,
  output logic                      rom_if_oe,
  output win_row_t                  win_row,
  output logic                      pad_en,
  output logic                      col_shift,
  output logic [ADDR_BITS-1:0]      ram_conv_a,
  output logic                      ram_conv_we,
  output logic                      ram_conv_oe,
  output logic                      pool_first,
  output logic                      pool_en,
  output logic [POOL_ADDR_BITS-1:0] ram_pool_a,
  output logic                      ram_pool_we,
  output logic                      done
);

  ctrl_state_e         state;
  logic [TAP_BITS-1:0] phase;
  logic [IMG_BITS-1:0] row_cnt;
  logic [IMG_BITS-1:0] col_cnt;
  logic [POOL_BITS-1:0] pool_row;
  logic [POOL_BITS-1:0] pool_col;

  win_row_t            row_sel;
  logic                sel_left;
  logic                sel_right;
  logic                win_active;
  logic                pad_slot;
  logic [IMG_BITS-1:0] src_row;
  logic [IMG_BITS-1:0] src_col;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= LOAD_W;
      phase    <= '0;
      row_cnt  <= '0;
      col_cnt  <= '0;
      pool_row <= '0;
      pool_col <= '0;
    end else begin
      case (state)
        LOAD_W, FILL_WIN: begin
          // Both last nine cycles
          if (phase == TAP_BITS'(KERNEL_TAPS - 1)) begin
            phase <= '0;
            state <= (state == LOAD_W) ? FILL_WIN : WRITE_CONV;
          end else begin
            phase <= phase + TAP_BITS'(1);
          end
        end
        SHIFT_COL: begin
          if (phase == TAP_BITS'(2)) begin
            phase <= '0;
            state <= WRITE_CONV;
          end else begin
            phase <= phase + TAP_BITS'(1);
          end
        end
        WRITE_CONV: begin
          if (col_cnt == IMG_BITS'(IMG_DIM - 1)) begin
            // Row counter wraps to 0 after the last row
            col_cnt <= '0;
            row_cnt <= row_cnt + IMG_BITS'(1);
            state   <= (row_cnt == IMG_BITS'(IMG_DIM - 1)) ? READ_POOL : FILL_WIN;
          end else begin
            col_cnt <= col_cnt + IMG_BITS'(1);
            state   <= SHIFT_COL;
          end
        end
        READ_POOL: begin
          if (phase == TAP_BITS'(3)) begin
            phase <= '0;
            state <= WRITE_POOL;
          end else begin
            phase <= phase + TAP_BITS'(1);
          end
        end
        WRITE_POOL: begin
          if (pool_col == POOL_BITS'(POOL_DIM - 1)) begin
            pool_col <= '0;
            pool_row <= pool_row + POOL_BITS'(1);
            state    <= (pool_row == POOL_BITS'(POOL_DIM - 1)) ? DONE : READ_POOL;
          end else begin
            pool_col <= pool_col + POOL_BITS'(1);
            state    <= READ_POOL;
          end
        end
        default: state <= DONE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Window slot and padding
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    row_sel   = ROW_NONE;
    sel_left  = 1'b0;
    sel_right = 1'b0;
    case (state)
      FILL_WIN: begin
        // Column-major with three rows per column
        case (phase)
          TAP_BITS'(0), TAP_BITS'(3), TAP_BITS'(6): row_sel = ROW_TOP;
          TAP_BITS'(1), TAP_BITS'(4), TAP_BITS'(7): row_sel = ROW_MID;
          default:                                  row_sel = ROW_BOT;
        endcase
        sel_left  = (phase < TAP_BITS'(3));
        sel_right = (phase > TAP_BITS'(5));
      end
      SHIFT_COL: begin
        case (phase)
          TAP_BITS'(0): row_sel = ROW_TOP;
          TAP_BITS'(1): row_sel = ROW_MID;
          default:      row_sel = ROW_BOT;
        endcase
        sel_right = 1'b1;
      end
      default: ;
    endcase
  end

  // Source pixel wraps modulo IMG_DIM; a wrapped slot is always padded
  assign src_row = (row_sel == ROW_TOP) ? row_cnt - IMG_BITS'(1) :
                   (row_sel == ROW_BOT) ? row_cnt + IMG_BITS'(1) : row_cnt;
  assign src_col = sel_left  ? col_cnt - IMG_BITS'(1) :
                   sel_right ? col_cnt + IMG_BITS'(1) : col_cnt;

  assign pad_slot = (row_sel == ROW_TOP && row_cnt == '0) ||
                    (row_sel == ROW_BOT && row_cnt == IMG_BITS'(IMG_DIM - 1)) ||
                    (sel_left && col_cnt == '0) ||
                    (sel_right && col_cnt == IMG_BITS'(IMG_DIM - 1));

  assign win_active = (state == FILL_WIN) || (state == SHIFT_COL);
  assign rom_if_a   = {src_row, src_col};
  assign rom_if_oe  = win_active && !pad_slot;
  assign pad_en     = win_active && pad_slot;
  assign win_row    = row_sel;

  // New right column opens on the top-row cycle
  assign col_shift = win_active && (row_sel == ROW_TOP);

  ////////////////////////////////////////////////////////////////////////////
  // Weight, conv and pool memories
  ////////////////////////////////////////////////////////////////////////////

  // Weight fetch stays quiet while rst is held
  assign rom_w_a  = phase;
  assign rom_w_oe = (state == LOAD_W) && !rst;
  assign w_load   = (state == LOAD_W) && !rst;

  // Phase bit 1 picks the block row and bit 0 the block column
  assign ram_conv_a = (state == WRITE_CONV) ? {row_cnt, col_cnt} :
                      {pool_row, phase[1], pool_col, phase[0]};
  assign ram_conv_we = (state == WRITE_CONV);
  assign ram_conv_oe = (state == READ_POOL);

  assign pool_en     = (state == READ_POOL);
  assign pool_first  = (state == READ_POOL) && (phase == '0);
  assign ram_pool_a  = {pool_row, pool_col};
  assign ram_pool_we = (state == WRITE_POOL);

  assign done = (state == DONE);

endmodule

// ==== verilog/window_buffer.sv ====
// Window is row-major, tap 0 top-left; new pixels always enter the right column
`timescale 1ns/10ps

module window_buffer
  import cnn_cfg_pkg::*;
  import cnn_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [PIX_BITS-1:0] pix,
  input  win_row_t            win_row,
  input  logic                pad_en,
  input  logic                col_shift,
  input  logic                rom_if_oe,
  output logic [PIX_BITS-1:0] window [KERNEL_TAPS]
);

  // Indexed [row][col], row 0 on top
  logic [PIX_BITS-1:0] win [3][3];
  logic                capture;
  logic [PIX_BITS-1:0] cap_pix;

  assign capture = rom_if_oe || pad_en;
  assign cap_pix = pad_en ? '0 : pix;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 3; c++) begin
          win[r][c] <= '0;
        end
      end
    end else begin
      // Shift left; column 2 keeps its value until rewritten
      if (col_shift) begin
        for (int r = 0; r < 3; r++) begin
          win[r][0] <= win[r][1];
          win[r][1] <= win[r][2];
        end
      end
      // Top row is win_row bit 2
      if (capture) begin
        for (int r = 0; r < 3; r++) begin
          if (win_row[2-r]) begin
            win[r][2] <= cap_pix;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flatten to taps
  ////////////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < 3; r++) begin : g_row
    for (genvar c = 0; c < 3; c++) begin : g_col
      assign window[r*3+c] = win[r][c];
    end
  end

endmodule

// ==== verilog/conv_engine.sv ====
// Weights load in tap order through w_din; result is combinational from window and weights
`timescale 1ns/10ps

module conv_engine
  import cnn_cfg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic signed [WGT_BITS-1:0] w_din,
  input  logic                       w_load,
  input  logic        [PIX_BITS-1:0] window [KERNEL_TAPS],
  output logic signed [ACC_BITS-1:0] conv_d
);

  logic signed [WGT_BITS-1:0] weight [KERNEL_TAPS];
  logic signed [PIX_BITS:0]   pix_s  [KERNEL_TAPS];
  logic signed [ACC_BITS-1:0] prod   [KERNEL_TAPS];

  ////////////////////////////////////////////////////////////////////////////
  // Weight chain
  ////////////////////////////////////////////////////////////////////////////

  // Enters at the top tap, so the first weight ends in tap 0
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < KERNEL_TAPS; k++) begin
        weight[k] <= '0;
      end
    end else if (w_load) begin
      for (int k = 0; k < KERNEL_TAPS - 1; k++) begin
        weight[k] <= weight[k+1];
      end
      weight[KERNEL_TAPS-1] <= w_din;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dot product
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < KERNEL_TAPS; k++) begin : g_tap
    // Zero-extend pixel so the multiply stays signed
    assign pix_s[k] = {1'b0, window[k]};
    assign prod[k]  = pix_s[k] * weight[k];
  end

  always_comb begin
    logic signed [ACC_BITS-1:0] acc;
    acc = '0;
    for (int k = 0; k < KERNEL_TAPS; k++) begin
      acc = acc + prod[k];
    end
    conv_d = acc;
  end

endmodule

// ==== verilog/max_pool.sv ====
// Signed max over the samples of one block; pool_first must mark the first sample
`timescale 1ns/10ps

module max_pool
  import cnn_cfg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic signed [ACC_BITS-1:0] sample,
  input  logic                       pool_first,
  input  logic                       pool_en,
  output logic signed [ACC_BITS-1:0] pool_d
);

  logic signed [ACC_BITS-1:0] run_max;

  // First sample restarts the block, later ones only raise it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_max <= '0;
    end else if (pool_first) begin
      run_max <= sample;
    end else if (pool_en && (sample > run_max)) begin
      run_max <= sample;
    end
  end

  // Held through WRITE_POOL
  assign pool_d = run_max;

endmodule

// ==== verilog/cnn_system_top.sv ====
// All four memories are external with combinational reads; run starts when rst falls
`timescale 1ns/10ps

module cnn_system_top
  import cnn_cfg_pkg::*;
  import cnn_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  // Weight ROM
  output logic [TAP_BITS-1:0]        rom_w_a,
  output logic                       rom_w_oe,
  input  logic signed [WGT_BITS-1:0] rom_w_q,
  // Image ROM
  output logic [ADDR_BITS-1:0]       rom_if_a,
  output logic                       rom_if_oe,
  input  logic [PIX_BITS-1:0]        rom_if_q,
  // Conv RAM
  output logic [ADDR_BITS-1:0]       ram_conv_a,
  output logic                       ram_conv_we,
  output logic                       ram_conv_oe,
  input  logic signed [ACC_BITS-1:0] ram_conv_q,
  output logic signed [ACC_BITS-1:0] conv_d,
  // Pool RAM
  output logic [POOL_ADDR_BITS-1:0]  ram_pool_a,
  output logic                       ram_pool_we,
  output logic signed [ACC_BITS-1:0] pool_d,
  output logic                       done
);

  logic                w_load;
  win_row_t            win_row;
  logic                pad_en;
  logic                col_shift;
  logic                pool_first;
  logic                pool_en;
  logic [PIX_BITS-1:0] window [KERNEL_TAPS];

  conv_controller u_conv_controller (
    .clk         (clk),
    .rst         (rst),
    .rom_w_a     (rom_w_a),
    .rom_w_oe    (rom_w_oe),
    .w_load      (w_load),
    .rom_if_a    (rom_if_a),
    .rom_if_oe   (rom_if_oe),
    .win_row     (win_row),
    .pad_en      (pad_en),
    .col_shift   (col_shift),
    .ram_conv_a  (ram_conv_a),
    .ram_conv_we (ram_conv_we),
    .ram_conv_oe (ram_conv_oe),
    .pool_first  (pool_first),
    .pool_en     (pool_en),
    .ram_pool_a  (ram_pool_a),
    .ram_pool_we (ram_pool_we),
    .done        (done)
  );

  window_buffer u_window_buffer (
    .clk       (clk),
    .rst       (rst),
    .pix       (rom_if_q),
    .win_row   (win_row),
    .pad_en    (pad_en),
    .col_shift (col_shift),
    .rom_if_oe (rom_if_oe),
    .window    (window)
  );

  conv_engine u_conv_engine (
    .clk    (clk),
    .rst    (rst),
    .w_din  (rom_w_q),
    .w_load (w_load),
    .window (window),
    .conv_d (conv_d)
  );

  max_pool u_max_pool (
    .clk        (clk),
    .rst        (rst),
    .sample     (ram_conv_q),
    .pool_first (pool_first),
    .pool_en    (pool_en),
    .pool_d     (pool_d)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
// Clock runs from time zero; a one-cycle restart request starts a fresh reset window
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD_NS  = 100.0,
  parameter int  RST_CYCLES = 8
) (
  input  logic restart,
  output logic clk,
  output logic rst
);

  logic rst_q   = 1'b1;
  int   rst_cnt = RST_CYCLES;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // Reset drops after RST_CYCLES rising edges
  always @(posedge clk) begin
    if (restart) begin
      rst_q   <= 1'b1;
      rst_cnt <= RST_CYCLES;
    end else if (rst_cnt > 0) begin
      rst_cnt <= rst_cnt - 1;
      if (rst_cnt == 1) begin
        rst_q <= 1'b0;
      end
    end
  end

  assign rst = rst_q;

endmodule

// ==== dv/tb_cnn_system.sv ====
// Memories are modeled here with same-cycle reads; every case restarts the DUT through reset
`timescale 1ns/10ps

module tb_cnn_system
  import cnn_cfg_pkg::*;
();

  localparam int N_PIX           = IMG_DIM * IMG_DIM;
  localparam int N_POOL          = POOL_DIM * POOL_DIM;
  localparam int N_CASES         = 5;
  localparam int RUN_CYCLES      = 9 + IMG_DIM * (9 + 1 + (IMG_DIM - 1) * 4) + N_POOL * 5;
  localparam int DONE_TIMEOUT    = 2000;
  localparam int RELEASE_TIMEOUT = 50;
  localparam int MID_RESET_AT    = 150;

  typedef enum int {IMG_RAMP, IMG_CONST, IMG_RAND} img_kind_e;
  typedef enum int {W_IDENT, W_ONES, W_RAND, W_CONST, W_NEG} wgt_kind_e;

  typedef struct {
    img_kind_e                  img_kind;
    logic [PIX_BITS-1:0]        img_val;
    wgt_kind_e                  wgt_kind;
    logic signed [WGT_BITS-1:0] wgt_val;
    bit                         exp_neg;
    bit                         mid_reset;
    int                         exp_cycles;
  } case_t;

  logic                        clk;
  logic                        rst;
  logic                        restart;
  logic [TAP_BITS-1:0]         rom_w_a;
  logic                        rom_w_oe;
  logic signed [WGT_BITS-1:0]  rom_w_q;
  logic [ADDR_BITS-1:0]        rom_if_a;
  logic                        rom_if_oe;
  logic [PIX_BITS-1:0]         rom_if_q;
  logic [ADDR_BITS-1:0]        ram_conv_a;
  logic                        ram_conv_we;
  logic                        ram_conv_oe;
  logic signed [ACC_BITS-1:0]  ram_conv_q;
  logic signed [ACC_BITS-1:0]  conv_d;
  logic [POOL_ADDR_BITS-1:0]   ram_pool_a;
  logic                        ram_pool_we;
  logic signed [ACC_BITS-1:0]  pool_d;
  logic                        done;

  logic [PIX_BITS-1:0]         img_rom  [N_PIX];
  logic signed [WGT_BITS-1:0]  wgt_rom  [1 << TAP_BITS];
  logic signed [ACC_BITS-1:0]  conv_mem [N_PIX];
  logic signed [ACC_BITS-1:0]  pool_mem [N_POOL];

  // Stimulus sources and reference results
  case_t                       cases    [N_CASES];
  logic [PIX_BITS-1:0]         img_src  [N_PIX];
  logic signed [WGT_BITS-1:0]  wgt_src  [KERNEL_TAPS];
  logic signed [ACC_BITS-1:0]  exp_conv [N_PIX];
  logic signed [ACC_BITS-1:0]  exp_pool [N_POOL];
  logic [31:0]                 rng;

  // Bus activity seen by the monitor since the last reset
  int w_reads     [1 << TAP_BITS];
  int if_reads    [N_PIX];
  int conv_writes [N_PIX];
  bit if_started;
  bit done_seen;
  int conv_errs;
  int pool_errs;
  int seq_errs;
  int mon_errs;

  tb_clock_gen u_clock_gen (
    .restart (restart),
    .clk     (clk),
    .rst     (rst)
  );

  cnn_system_top u_cnn_system_top (
    .clk         (clk),
    .rst         (rst),
    .rom_w_a     (rom_w_a),
    .rom_w_oe    (rom_w_oe),
    .rom_w_q     (rom_w_q),
    .rom_if_a    (rom_if_a),
    .rom_if_oe   (rom_if_oe),
    .rom_if_q    (rom_if_q),
    .ram_conv_a  (ram_conv_a),
    .ram_conv_we (ram_conv_we),
    .ram_conv_oe (ram_conv_oe),
    .ram_conv_q  (ram_conv_q),
    .conv_d      (conv_d),
    .ram_pool_a  (ram_pool_a),
    .ram_pool_we (ram_pool_we),
    .pool_d      (pool_d),
    .done        (done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////////////////////////////////////////

  assign rom_w_q    = rom_w_oe ? wgt_rom[rom_w_a] : '0;
  assign rom_if_q   = rom_if_oe ? img_rom[rom_if_a] : '0;
  assign ram_conv_q = ram_conv_oe ? conv_mem[ram_conv_a] : '0;

  // RAMs refill with an address pattern while in reset, so a missed write shows
  always @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < N_PIX; a++) begin
        conv_mem[a] <= ACC_BITS'(32'h000A_5A50 + a * 32'h0000_0301);
      end
      for (int a = 0; a < N_POOL; a++) begin
        pool_mem[a] <= ACC_BITS'(32'h0003_C3C0 + a * 32'h0000_1105);
      end
    end else begin
      if (ram_conv_we) begin
        conv_mem[ram_conv_a] <= conv_d;
      end
      if (ram_pool_we) begin
        pool_mem[ram_pool_a] <= pool_d;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      for (int k = 0; k < (1 << TAP_BITS); k++) begin
        w_reads[k] = 0;
      end
      for (int a = 0; a < N_PIX; a++) begin
        if_reads[a]    = 0;
        conv_writes[a] = 0;
      end
      if_started = 1'b0;
      done_seen  = 1'b0;
    end else begin
      if (rom_w_oe) begin
        if (if_started || !u_cnn_system_top.w_load || rom_w_a >= TAP_BITS'(KERNEL_TAPS)) begin
          mon_errs++;
          $display("weight ROM read at address %0d is out of order or lacks w_load", rom_w_a);
        end
        w_reads[rom_w_a]++;
      end
      if (rom_if_oe) begin
        if_started = 1'b1;
        if_reads[rom_if_a]++;
      end
      if (ram_conv_we) begin
        conv_writes[ram_conv_a]++;
      end
      if (done_seen && !done) begin
        mon_errs++;
        $display("done fell before the next reset");
      end
      if (done_seen && (ram_conv_we || ram_pool_we)) begin
        mon_errs++;
        $display("a RAM write enable was active after done");
      end
      if (done) begin
        done_seen = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_conv(input int addr, input logic signed [ACC_BITS-1:0] got,
                            input logic signed [ACC_BITS-1:0] exp);
    if (got !== exp) begin
      conv_errs++;
      $display("error conv_mem[%0d] got %h expected %h", addr, got, exp);
    end
  endtask

  task automatic check_pool(input int addr, input logic signed [ACC_BITS-1:0] got,
                            input logic signed [ACC_BITS-1:0] exp);
    if (got !== exp) begin
      pool_errs++;
      $display("error pool_mem[%0d] got %h expected %h", addr, got, exp);
    end
  endtask

  task automatic report_seq(input string msg);
    seq_errs++;
    $display("%s", msg);
  endtask

  task automatic print_summary();
    $display("errors: conv %0d pool %0d sequence %0d", conv_errs, pool_errs,
             seq_errs + mon_errs);
  endtask

  task automatic abort_run(input string why);
    report_seq(why);
    print_summary();
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
  endtask

  task automatic wait_release();
    bit released;
    released = 1'b0;
    for (int i = 0; i < RELEASE_TIMEOUT && !released; i++) begin
      @(negedge clk);
      released = !rst;
    end
    if (!released) begin
      abort_run("reset was not released in time");
    end
  endtask

  // First cycle after release was already seen by wait_release
  task automatic wait_done(output int cycles);
    bit seen;
    seen   = 1'b0;
    cycles = 1;
    for (int i = 0; i < DONE_TIMEOUT && !seen; i++) begin
      @(negedge clk);
      if (done) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      abort_run("done did not rise within the timeout");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_case(input int idx);
    for (int a = 0; a < N_PIX; a++) begin
      case (cases[idx].img_kind)
        IMG_RAMP:  img_src[a] = PIX_BITS'(a * 4);
        IMG_CONST: img_src[a] = cases[idx].img_val;
        default: begin
          rng        = xorshift32(rng);
          img_src[a] = rng[PIX_BITS-1:0];
        end
      endcase
    end
    for (int k = 0; k < KERNEL_TAPS; k++) begin
      case (cases[idx].wgt_kind)
        W_IDENT: wgt_src[k] = (k == 4) ? WGT_BITS'(1) : '0;
        W_ONES:  wgt_src[k] = WGT_BITS'(1);
        W_CONST: wgt_src[k] = cases[idx].wgt_val;
        W_NEG:   wgt_src[k] = WGT_BITS'(-7 * (k + 1));
        default: begin
          rng        = xorshift32(rng);
          wgt_src[k] = rng[WGT_BITS-1:0];
        end
      endcase
    end
    pulse_reset();
    for (int a = 0; a < N_PIX; a++) begin
      img_rom[a] <= img_src[a];
    end
    for (int k = 0; k < (1 << TAP_BITS); k++) begin
      wgt_rom[k] <= (k < KERNEL_TAPS) ? wgt_src[k] : WGT_BITS'(32'h5C ^ (k * 3));
    end
  endtask

  // Zero-padded 3x3 correlation, tap k is weight k row-major
  task automatic build_model();
    int sum;
    int rr;
    int cc;
    int base;
    logic signed [ACC_BITS-1:0] m;
    for (int r = 0; r < IMG_DIM; r++) begin
      for (int c = 0; c < IMG_DIM; c++) begin
        sum = 0;
        for (int dr = 0; dr < 3; dr++) begin
          for (int dc = 0; dc < 3; dc++) begin
            rr = r + dr - 1;
            cc = c + dc - 1;
            if (rr >= 0 && rr < IMG_DIM && cc >= 0 && cc < IMG_DIM) begin
              sum += int'(img_src[rr * IMG_DIM + cc]) * int'(wgt_src[dr * 3 + dc]);
            end
          end
        end
        exp_conv[r * IMG_DIM + c] = ACC_BITS'(sum);
      end
    end
    for (int pr = 0; pr < POOL_DIM; pr++) begin
      for (int pc = 0; pc < POOL_DIM; pc++) begin
        base = 2 * pr * IMG_DIM + 2 * pc;
        m    = exp_conv[base];
        if (exp_conv[base + 1] > m) begin
          m = exp_conv[base + 1];
        end
        if (exp_conv[base + IMG_DIM] > m) begin
          m = exp_conv[base + IMG_DIM];
        end
        if (exp_conv[base + IMG_DIM + 1] > m) begin
          m = exp_conv[base + IMG_DIM + 1];
        end
        exp_pool[pr * POOL_DIM + pc] = m;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_idle();
    if (!rst) begin
      report_seq("reset did not assert after the restart request");
    end
    if (done || rom_w_oe || rom_if_oe || ram_conv_we || ram_conv_oe || ram_pool_we) begin
      report_seq("done or an enable stayed high after a mid-run reset");
    end
  endtask

  task automatic check_results(input int idx);
    int exp_reads;
    int sr;
    for (int k = 0; k < KERNEL_TAPS; k++) begin
      if (w_reads[k] != 1) begin
        report_seq($sformatf("weight ROM address %0d was read %0d times", k, w_reads[k]));
      end
    end
    for (int a = 0; a < N_PIX; a++) begin
      // Each image row feeds the output rows above, at and below it
      sr        = a / IMG_DIM;
      exp_reads = 3;
      if (sr == 0) begin
        exp_reads--;
      end
      if (sr == IMG_DIM - 1) begin
        exp_reads--;
      end
      if (if_reads[a] != exp_reads) begin
        report_seq($sformatf("image ROM address %0d read %0d times instead of %0d",
                             a, if_reads[a], exp_reads));
      end
      if (conv_writes[a] != 1) begin
        report_seq($sformatf("conv RAM address %0d written %0d times", a, conv_writes[a]));
      end
      check_conv(a, conv_mem[a], exp_conv[a]);
    end
    for (int p = 0; p < N_POOL; p++) begin
      check_pool(p, pool_mem[p], exp_pool[p]);
      if (cases[idx].exp_neg && pool_mem[p] > 0) begin
        pool_errs++;
        $display("error pool_mem[%0d] %h is above zero for a negative kernel", p, pool_mem[p]);
      end
    end
  endtask

  task automatic run_case(input int idx);
    int cycles;
    load_case(idx);
    build_model();
    if (cases[idx].mid_reset) begin
      wait_release();
      for (int i = 0; i < MID_RESET_AT; i++) begin
        @(negedge clk);
      end
      pulse_reset();
      @(negedge clk);
      check_idle();
    end
    wait_release();
    wait_done(cycles);
    if (cycles != cases[idx].exp_cycles) begin
      report_seq($sformatf("case %0d: done rose after %0d cycles instead of %0d",
                           idx, cycles, cases[idx].exp_cycles));
    end
    // A few idle cycles so the monitor sees done hold
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
    end
    check_results(idx);
  endtask

  initial begin
    restart   = 1'b0;
    rng       = 32'd8;
    conv_errs = 0;
    pool_errs = 0;
    seq_errs  = 0;
    mon_errs  = 0;
    for (int a = 0; a < N_PIX; a++) begin
      img_rom[a] = PIX_BITS'(a * 5 + 3);
    end
    for (int k = 0; k < (1 << TAP_BITS); k++) begin
      wgt_rom[k] = '0;
    end

    cases[0] = '{IMG_RAMP,  8'd0,   W_IDENT, 8'h00, 1'b0, 1'b0, RUN_CYCLES};
    cases[1] = '{IMG_CONST, 8'd37,  W_ONES,  8'h00, 1'b0, 1'b0, RUN_CYCLES};
    cases[2] = '{IMG_RAND,  8'd0,   W_RAND,  8'h00, 1'b0, 1'b1, RUN_CYCLES};
    cases[3] = '{IMG_CONST, 8'd255, W_CONST, 8'h80, 1'b1, 1'b0, RUN_CYCLES};
    cases[4] = '{IMG_RAND,  8'd0,   W_NEG,   8'h00, 1'b1, 1'b0, RUN_CYCLES};

    for (int i = 0; i < N_CASES; i++) begin
      run_case(i);
    end

    print_summary();
    if (conv_errs + pool_errs + seq_errs + mon_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/cnn_cfg_pkg.sv
verilog/cnn_ctrl_pkg.sv
verilog/conv_controller.sv
verilog/window_buffer.sv
verilog/conv_engine.sv
verilog/max_pool.sv
verilog/cnn_system_top.sv
dv/tb_clock_gen.sv
dv/tb_cnn_system.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP      ?= tb_cnn_system
FLIST    ?= flist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
FAIL_MSG := SIMULATION FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for failure"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)
